//--- gb_bus_pkg.sv
package gb_bus_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address word
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		logic [7:0] page;
		logic [7:0] offset;
	} gb_addr_parts_t;

	// Same 16 bits, seen flat or as page and offset
	typedef union packed {
		logic [15:0]    raw;
		gb_addr_parts_t part;
	} gb_addr_t;

	typedef enum logic [1:0] {
		op_rd = 2'd0,
		op_wr = 2'd1
	} bus_op_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Memory map
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int          OAM_BYTES    = 160;
	localparam logic [15:0] DMA_REG_ADDR = 16'hFF46;
	localparam logic [15:0] OAM_BASE     = 16'hFE00;
	localparam logic [15:0] OAM_LAST     = 16'hFE9F;

	// Everything from here up stays inside the chip
	localparam logic [15:0] INT_BASE     = 16'hFE00;

	// Start of the RAM chip-select window, which ends at INT_BASE
	localparam logic [15:0] CS_BASE      = 16'hA000;

endpackage

//--- ext_bus_if.sv
`timescale 1ns/1ps

interface ext_bus_if;
	import gb_bus_pkg::*;

	// Request side, held by the master until done
	logic       req;
	bus_op_t    op;
	gb_addr_t   addr;
	logic [7:0] wdata;

	// Response side, rdata valid with done
	logic       done;
	logic [7:0] rdata;

	modport master (
		output req,
		output op,
		output addr,
		output wdata,
		input  done,
		input  rdata
	);

	modport slave (
		input  req,
		input  op,
		input  addr,
		input  wdata,
		output done,
		output rdata
	);

endinterface

//--- ext_cpu_busses.sv
`timescale 1ns/1ps

module ext_cpu_busses #(
	parameter int BUS_CYCLES = 2
) (
	input  logic        clk,
	input  logic        rst,
	ext_bus_if.slave    bus,
	output logic [15:0] ext_a,
	output logic [7:0]  ext_d_out,
	output logic        ext_d_oe,
	input  logic [7:0]  ext_d_in,
	output logic        ext_rd_n,
	output logic        ext_wr_n,
	output logic        ext_cs_n
);
	import gb_bus_pkg::*;

	localparam int CNT_W = (BUS_CYCLES > 2) ? $clog2(BUS_CYCLES) : 1;

	logic             active;
	logic [CNT_W-1:0] cnt;
	logic             done_q;
	logic [7:0]       rdata_q;
	logic             cs_hit;
	logic             start;
	logic             last;

	// RAM select window A000-FDFF, decoded from the page byte only
	assign cs_hit = (bus.addr.part.page >= CS_BASE[15:8]) &&
	                (bus.addr.part.page < INT_BASE[15:8]);

	assign start = bus.req && !active;
	assign last  = active && (cnt == '0);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Strobe sequencer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (rst) begin
			active   <= 1'b0;
			cnt      <= '0;
			done_q   <= 1'b0;
			ext_rd_n <= 1'b1;
			ext_wr_n <= 1'b1;
			ext_cs_n <= 1'b1;
			ext_d_oe <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (start) begin
				active   <= 1'b1;
				cnt      <= CNT_W'(BUS_CYCLES - 1);
				ext_rd_n <= (bus.op != op_rd);
				ext_wr_n <= (bus.op != op_wr);
				ext_cs_n <= !cs_hit;
				ext_d_oe <= (bus.op == op_wr);
			end else if (last) begin
				// Release all strobes together
				active   <= 1'b0;
				done_q   <= 1'b1;
				ext_rd_n <= 1'b1;
				ext_wr_n <= 1'b1;
				ext_cs_n <= 1'b1;
				ext_d_oe <= 1'b0;
			end else if (active) begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address, write data and read capture
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (start) begin
			ext_a     <= bus.addr.raw;
			ext_d_out <= bus.wdata;
		end
		// Sampled while the read strobe is still low
		if (last && !ext_rd_n) begin
			rdata_q <= ext_d_in;
		end
	end

	assign bus.done  = done_q;
	assign bus.rdata = rdata_q;

endmodule

//--- oam_dma.sv
`timescale 1ns/1ps

module oam_dma (
	input  logic       clk,
	input  logic       rst,
	input  logic       dma_start,
	input  logic [7:0] dma_page,
	output logic       dma_active,
	ext_bus_if.master  bus,
	input  logic       cpu_oam_we,
	input  logic [7:0] cpu_oam_addr,
	input  logic [7:0] cpu_oam_wdata,
	output logic       oam_we,
	output logic [7:0] oam_waddr,
	output logic [7:0] oam_wdata
);
	import gb_bus_pkg::*;

	localparam logic [7:0] LAST_IDX = 8'(OAM_BYTES - 1);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_WAIT = 2'd1;
	localparam logic [1:0] S_LAST = 2'd2;

	logic [1:0] state;
	logic [7:0] idx;
	logic [7:0] page_q;
	logic       discard;
	logic       req_q;
	gb_addr_t   addr_q;
	logic       busy;
	logic       issue;
	logic [7:0] issue_page;
	logic [7:0] issue_off;
	logic       dma_we;
	logic [7:0] dma_waddr;
	logic [7:0] dma_wdata;

	// A read is still in flight on the bus
	assign busy = (state == S_WAIT) && !bus.done;

	always_comb begin
		issue      = 1'b0;
		issue_page = page_q;
		issue_off  = idx;
		if (dma_start) begin
			issue      = !busy;
			issue_page = dma_page;
			issue_off  = 8'h00;
		end else if ((state == S_WAIT) && bus.done) begin
			if (discard) begin
				issue = 1'b1;
			end else if (idx != LAST_IDX) begin
				issue     = 1'b1;
				issue_off = idx + 8'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= S_IDLE;
			idx     <= '0;
			discard <= 1'b0;
			req_q   <= 1'b0;
			dma_we  <= 1'b0;
		end else begin
			req_q  <= issue;
			dma_we <= 1'b0;
			if (dma_start) begin
				// Restart, an old read still pending gets thrown away
				state   <= S_WAIT;
				idx     <= '0;
				discard <= busy;
			end else begin
				case (state)
					S_WAIT: begin
						if (bus.done && discard) begin
							discard <= 1'b0;
						end else if (bus.done) begin
							dma_we <= 1'b1;
							if (idx == LAST_IDX) begin
								state <= S_LAST;
							end else begin
								idx <= idx + 8'd1;
							end
						end
					end
					S_LAST: state <= S_IDLE;
					default: state <= S_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (dma_start) begin
			page_q <= dma_page;
		end
		if (issue) begin
			addr_q.part.page   <= issue_page;
			addr_q.part.offset <= issue_off;
		end
		if ((state == S_WAIT) && bus.done) begin
			dma_waddr <= idx;
			dma_wdata <= bus.rdata;
		end
	end

	assign dma_active = (state != S_IDLE);

	assign bus.req   = req_q;
	assign bus.op    = op_rd;
	assign bus.addr  = addr_q;
	assign bus.wdata = 8'h00;

	// CPU writes are only let through while no copy runs
	assign oam_we    = dma_we | cpu_oam_we;
	assign oam_waddr = dma_we ? dma_waddr : cpu_oam_addr;
	assign oam_wdata = dma_we ? dma_wdata : cpu_oam_wdata;

endmodule

//--- bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 cpu_rd,
	input  logic                 cpu_wr,
	input  gb_bus_pkg::gb_addr_t cpu_addr,
	input  logic [7:0]           cpu_wdata,
	output logic [7:0]           cpu_rdata,
	output logic                 cpu_done,
	ext_bus_if.slave             dma_bus,
	ext_bus_if.master            pin_bus,
	input  logic                 dma_active,
	output logic                 dma_start,
	output logic [7:0]           dma_page,
	output logic [7:0]           oam_raddr,
	input  logic [7:0]           oam_rdata,
	output logic                 cpu_oam_we,
	output logic [7:0]           cpu_oam_wdata
);
	import gb_bus_pkg::*;

	localparam logic [1:0] C_IDLE = 2'd0;
	localparam logic [1:0] C_INT  = 2'd1;
	localparam logic [1:0] C_WAIT = 2'd2;
	localparam logic [1:0] C_EXT  = 2'd3;

	logic [1:0] c_state;
	logic       cpu_req;
	logic       is_int;
	logic       is_oam;
	logic       is_dreg;
	logic       oam_hit_q;
	logic       cpu_ext_want;
	logic       grant_dma;
	logic       grant_cpu;
	logic       dma_pend;
	logic       p_busy;
	logic       p_dma;
	logic       pin_req_q;
	bus_op_t    pin_op_q;
	gb_addr_t   pin_addr_q;
	logic [7:0] pin_wdata_q;

	// A level still high during cpu_done is the request just finished
	assign cpu_req = (cpu_rd || cpu_wr) && !cpu_done;

	assign is_int  = (cpu_addr.raw >= INT_BASE);
	assign is_oam  = (cpu_addr.raw >= OAM_BASE) && (cpu_addr.raw <= OAM_LAST);
	assign is_dreg = (cpu_addr.raw == DMA_REG_ADDR);

	assign oam_raddr = cpu_addr.part.offset;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pin channel grant, DMA first
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign cpu_ext_want = (c_state == C_WAIT) ||
	                      ((c_state == C_IDLE) && cpu_req && !is_int);
	assign grant_dma    = !p_busy && (dma_pend || dma_bus.req);
	assign grant_cpu    = !p_busy && !grant_dma && !dma_active && cpu_ext_want;

	assign dma_bus.done  = pin_bus.done && p_dma;
	assign dma_bus.rdata = pin_bus.rdata;

	assign pin_bus.req   = pin_req_q;
	assign pin_bus.op    = pin_op_q;
	assign pin_bus.addr  = pin_addr_q;
	assign pin_bus.wdata = pin_wdata_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			c_state    <= C_IDLE;
			cpu_done   <= 1'b0;
			dma_start  <= 1'b0;
			cpu_oam_we <= 1'b0;
			dma_pend   <= 1'b0;
			p_busy     <= 1'b0;
			p_dma      <= 1'b0;
			pin_req_q  <= 1'b0;
		end else begin
			cpu_done   <= 1'b0;
			dma_start  <= 1'b0;
			cpu_oam_we <= 1'b0;
			pin_req_q  <= grant_dma || grant_cpu;
			dma_pend   <= (dma_pend || dma_bus.req) && !grant_dma;
			if (grant_dma || grant_cpu) begin
				p_busy <= 1'b1;
				p_dma  <= grant_dma;
			end else if (pin_bus.done) begin
				p_busy <= 1'b0;
			end

			case (c_state)
				C_IDLE: begin
					if (cpu_req && is_int) begin
						c_state    <= C_INT;
						dma_start  <= cpu_wr && is_dreg;
						cpu_oam_we <= cpu_wr && is_oam && !dma_active;
					end else if (cpu_req) begin
						c_state <= grant_cpu ? C_EXT : C_WAIT;
					end
				end
				C_INT: begin
					cpu_done <= 1'b1;
					c_state  <= C_IDLE;
				end
				C_WAIT: begin
					if (grant_cpu) begin
						c_state <= C_EXT;
					end
				end
				default: begin
					if (pin_bus.done && !p_dma) begin
						cpu_done <= 1'b1;
						c_state  <= C_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (grant_dma) begin
			pin_op_q    <= dma_bus.op;
			pin_addr_q  <= dma_bus.addr;
			pin_wdata_q <= dma_bus.wdata;
		end else if (grant_cpu) begin
			pin_op_q    <= cpu_wr ? op_wr : op_rd;
			pin_addr_q  <= cpu_addr;
			pin_wdata_q <= cpu_wdata;
		end
		if (c_state == C_IDLE) begin
			// OAM is locked out for the CPU while a copy runs
			oam_hit_q     <= is_oam && cpu_rd && !dma_active;
			cpu_oam_wdata <= cpu_wdata;
			if (cpu_req && cpu_wr && is_dreg) begin
				dma_page <= cpu_wdata;
			end
		end
		if (c_state == C_INT) begin
			cpu_rdata <= oam_hit_q ? oam_rdata : 8'hFF;
		end else if ((c_state == C_EXT) && pin_bus.done && !p_dma) begin
			cpu_rdata <= pin_bus.rdata;
		end
	end

endmodule

//--- oam_ram.sv
`timescale 1ns/1ps

module oam_ram (
	input  logic       clk,
	input  logic       we,
	input  logic [7:0] waddr,
	input  logic [7:0] wdata,
	input  logic [7:0] raddr,
	output logic [7:0] rdata
);
	import gb_bus_pkg::*;

	localparam logic [7:0] DEPTH = 8'(OAM_BYTES);

	logic [7:0] mem [OAM_BYTES];
	logic       w_ok;
	logic       r_ok;

	// Index range is 0-255 but only 160 bytes exist
	assign w_ok = (waddr < DEPTH);
	assign r_ok = (raddr < DEPTH);

	always_ff @(posedge clk) begin
		if (we && w_ok) begin
			mem[waddr] <= wdata;
		end
	end

	// Registered read, data shows one cycle after raddr
	always_ff @(posedge clk) begin
		if (r_ok) begin
			rdata <= mem[raddr];
		end else begin
			rdata <= 8'hFF;
		end
	end

endmodule

//--- gb_ext_bus_top.sv
`timescale 1ns/1ps

module gb_ext_bus_top #(
	parameter int BUS_CYCLES = 2
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        cpu_rd,
	input  logic        cpu_wr,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_wdata,
	output logic [7:0]  cpu_rdata,
	output logic        cpu_done,
	output logic [15:0] ext_a,
	output logic [7:0]  ext_d_out,
	output logic        ext_d_oe,
	input  logic [7:0]  ext_d_in,
	output logic        ext_rd_n,
	output logic        ext_wr_n,
	output logic        ext_cs_n,
	output logic        dma_active
);

	ext_bus_if dma_bus ();
	ext_bus_if pin_bus ();

	logic       dma_start;
	logic [7:0] dma_page;
	logic       oam_we;
	logic [7:0] oam_waddr;
	logic [7:0] oam_wdata;
	logic [7:0] oam_raddr;
	logic [7:0] oam_rdata;
	logic       cpu_oam_we;
	logic [7:0] cpu_oam_wdata;

	bus_arbiter u_arbiter (
		.clk           (clk),
		.rst           (rst),
		.cpu_rd        (cpu_rd),
		.cpu_wr        (cpu_wr),
		.cpu_addr      (cpu_addr),
		.cpu_wdata     (cpu_wdata),
		.cpu_rdata     (cpu_rdata),
		.cpu_done      (cpu_done),
		.dma_bus       (dma_bus.slave),
		.pin_bus       (pin_bus.master),
		.dma_active    (dma_active),
		.dma_start     (dma_start),
		.dma_page      (dma_page),
		.oam_raddr     (oam_raddr),
		.oam_rdata     (oam_rdata),
		.cpu_oam_we    (cpu_oam_we),
		.cpu_oam_wdata (cpu_oam_wdata)
	);

	ext_cpu_busses #(
		.BUS_CYCLES (BUS_CYCLES)
	) u_pins (
		.clk       (clk),
		.rst       (rst),
		.bus       (pin_bus.slave),
		.ext_a     (ext_a),
		.ext_d_out (ext_d_out),
		.ext_d_oe  (ext_d_oe),
		.ext_d_in  (ext_d_in),
		.ext_rd_n  (ext_rd_n),
		.ext_wr_n  (ext_wr_n),
		.ext_cs_n  (ext_cs_n)
	);

	oam_dma u_dma (
		.clk           (clk),
		.rst           (rst),
		.dma_start     (dma_start),
		.dma_page      (dma_page),
		.dma_active    (dma_active),
		.bus           (dma_bus.master),
		.cpu_oam_we    (cpu_oam_we),
		.cpu_oam_addr  (oam_raddr),
		.cpu_oam_wdata (cpu_oam_wdata),
		.oam_we        (oam_we),
		.oam_waddr     (oam_waddr),
		.oam_wdata     (oam_wdata)
	);

	oam_ram u_oam (
		.clk   (clk),
		.we    (oam_we),
		.waddr (oam_waddr),
		.wdata (oam_wdata),
		.raddr (oam_raddr),
		.rdata (oam_rdata)
	);

endmodule

//--- tb_ext_bus_checker.sv
`timescale 1ns/1ps

module tb_ext_bus_checker #(
	parameter int BUS_CYCLES = 2
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        cpu_rd,
	input  logic        cpu_wr,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_wdata,
	input  logic [7:0]  cpu_rdata,
	input  logic        cpu_done,
	input  logic [15:0] ext_a,
	input  logic [7:0]  ext_d_out,
	input  logic        ext_d_oe,
	input  logic        ext_rd_n,
	input  logic        ext_wr_n,
	input  logic        ext_cs_n,
	input  logic        dma_active,
	input  logic        exp_valid,
	input  logic [7:0]  exp_rdata,
	output int          check_count,
	output int          error_count
);

	logic [7:0] ram_model [8192];
	logic [7:0] oam_model [160];
	logic [7:0] page = 8'h00;
	logic       in_req = 1'b0;
	logic       dma_at_start = 1'b0;
	logic       dma_was = 1'b0;
	logic       seen_req = 1'b0;
	logic       reset_seen = 1'b0;
	int         lat = 0;
	int         rd_low = 0;
	int         wr_low = 0;
	int         dma_next = 0;
	int         n_checks = 0;
	int         n_errors = 0;

	assign check_count = n_checks;
	assign error_count = n_errors;

	task automatic report_error(input string msg);
		n_errors++;
		$display("FAILED at %0t ns: %s", $time, msg);
	endtask

	// Reference memory map as seen by the CPU
	function automatic logic [7:0] expected_read(input logic [15:0] a, input logic oam_locked);
		if (a < 16'h8000) begin
			return a[7:0] ^ a[15:8];
		end else if (a >= 16'hA000 && a < 16'hC000) begin
			return ram_model[a[12:0]];
		end else if (a >= 16'hFE00 && a <= 16'hFE9F && !oam_locked) begin
			return oam_model[a[7:0]];
		end
		return 8'hFF;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// CPU request completion
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic close_request();
		logic       is_int;
		int         want_lat;
		logic [7:0] want;
		is_int   = (cpu_addr >= 16'hFE00);
		want_lat = is_int ? 2 : BUS_CYCLES + 3;
		n_checks++;
		// External access held off by DMA has no fixed latency
		if ((is_int || !dma_at_start) && lat != want_lat) begin
			report_error($sformatf("access to %h took %0d cycles, expected %0d",
				cpu_addr, lat, want_lat));
		end
		if (!is_int && dma_active) begin
			report_error($sformatf("external access to %h finished during DMA", cpu_addr));
		end
		if (cpu_rd) begin
			want = expected_read(cpu_addr, dma_at_start);
			if (exp_valid && exp_rdata !== want) begin
				report_error($sformatf("table expects %h at %h, model gives %h",
					exp_rdata, cpu_addr, want));
			end
			if (cpu_rdata !== want) begin
				report_error($sformatf("read of %h returned %h, expected %h",
					cpu_addr, cpu_rdata, want));
			end
		end else if (cpu_addr >= 16'hA000 && cpu_addr < 16'hC000) begin
			ram_model[cpu_addr[12:0]] = cpu_wdata;
		end else if (cpu_addr >= 16'hFE00 && cpu_addr <= 16'hFE9F && !dma_at_start) begin
			oam_model[cpu_addr[7:0]] = cpu_wdata;
		end else if (cpu_addr == 16'hFF46) begin
			page = cpu_wdata;
		end
		in_req = 1'b0;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pin rules
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check_pins();
		logic cs_want;
		if (!seen_req && !ext_rd_n) begin
			report_error("read strobe seen before the first request");
		end
		if (!ext_rd_n || !ext_wr_n) begin
			n_checks++;
			cs_want = !(ext_a >= 16'hA000 && ext_a < 16'hFE00);
			if (!ext_rd_n && !ext_wr_n) begin
				report_error("read and write strobes low together");
			end
			if (ext_cs_n !== cs_want || ext_d_oe !== !ext_wr_n) begin
				report_error($sformatf("cs_n %b oe %b wrong at address %h",
					ext_cs_n, ext_d_oe, ext_a));
			end
			if (dma_active) begin
				if (!ext_wr_n || ext_a !== {page, 8'(dma_next)}) begin
					report_error($sformatf("DMA pin cycle at %h, expected read of %h",
						ext_a, {page, 8'(dma_next)}));
				end
			end else if (!in_req || cpu_addr >= 16'hFE00) begin
				report_error("pin cycle with no external CPU request");
			end else if (ext_a !== cpu_addr || (!ext_wr_n && ext_d_out !== cpu_wdata)) begin
				report_error($sformatf("pins show %h/%h for CPU access %h/%h",
					ext_a, ext_d_out, cpu_addr, cpu_wdata));
			end
		end else if (!ext_cs_n || ext_d_oe) begin
			report_error("chip select or data enable active without a strobe");
		end

		// Strobe widths
		if (!ext_rd_n) begin
			rd_low++;
		end else if (rd_low != 0) begin
			n_checks++;
			if (rd_low != BUS_CYCLES) begin
				report_error($sformatf("ext_rd_n low for %0d cycles", rd_low));
			end
			if (dma_active) begin
				dma_next++;
			end
			rd_low = 0;
		end
		if (!ext_wr_n) begin
			wr_low++;
		end else if (wr_low != 0) begin
			n_checks++;
			if (wr_low != BUS_CYCLES) begin
				report_error($sformatf("ext_wr_n low for %0d cycles", wr_low));
			end
			wr_low = 0;
		end
	endtask

	always @(posedge clk) begin
		if (rst) begin
			if (reset_seen) begin
				n_checks++;
				if (!ext_rd_n || !ext_wr_n || !ext_cs_n || ext_d_oe || cpu_done || dma_active) begin
					report_error("outputs not inactive during reset");
				end
			end
			reset_seen = 1'b1;
			in_req     = 1'b0;
			dma_was    = 1'b0;
			rd_low     = 0;
			wr_low     = 0;
		end else begin
			if (dma_active && !dma_was) begin
				dma_next = 0;
			end
			// Copy finished, OAM now mirrors the source page
			if (!dma_active && dma_was) begin
				n_checks++;
				if (dma_next != 160) begin
					report_error($sformatf("DMA made %0d reads, expected 160", dma_next));
				end
				for (int i = 0; i < 160; i++) begin
					oam_model[8'(i)] = 8'(i) ^ page;
				end
			end
			dma_was = dma_active;

			if (in_req) begin
				lat++;
				if (cpu_done) begin
					close_request();
				end
			end else if (cpu_done) begin
				report_error("cpu_done without a CPU request");
			end else if (cpu_rd || cpu_wr) begin
				in_req       = 1'b1;
				seen_req     = 1'b1;
				lat          = 0;
				dma_at_start = dma_active;
			end
			check_pins();
		end
	end

endmodule

//--- tb_gb_ext_bus.sv
`timescale 1ns/1ps

module tb_gb_ext_bus;
	import gb_bus_pkg::*;

	localparam int BUS_CYCLES = 2;

	logic        clk;
	logic        rst;
	logic        cpu_rd;
	logic        cpu_wr;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_wdata;
	logic [7:0]  cpu_rdata;
	logic        cpu_done;
	logic [15:0] ext_a;
	logic [7:0]  ext_d_out;
	logic        ext_d_oe;
	logic [7:0]  ext_d_in;
	logic        ext_rd_n;
	logic        ext_wr_n;
	logic        ext_cs_n;
	logic        dma_active;
	logic        exp_valid;
	logic [7:0]  exp_rdata;
	int          check_count;
	int          error_count;
	int          cycles = 0;
	int          cycle_limit = 1000000;

	// Stimulus table
	bus_op_t     t_op   [$];
	logic [15:0] t_addr [$];
	logic [7:0]  t_data [$];
	logic [7:0]  t_exp  [$];

	logic [7:0]  cart_ram [8192];

	gb_ext_bus_top #(
		.BUS_CYCLES (BUS_CYCLES)
	) dut (
		.clk        (clk),
		.rst        (rst),
		.cpu_rd     (cpu_rd),
		.cpu_wr     (cpu_wr),
		.cpu_addr   (cpu_addr),
		.cpu_wdata  (cpu_wdata),
		.cpu_rdata  (cpu_rdata),
		.cpu_done   (cpu_done),
		.ext_a      (ext_a),
		.ext_d_out  (ext_d_out),
		.ext_d_oe   (ext_d_oe),
		.ext_d_in   (ext_d_in),
		.ext_rd_n   (ext_rd_n),
		.ext_wr_n   (ext_wr_n),
		.ext_cs_n   (ext_cs_n),
		.dma_active (dma_active)
	);

	tb_ext_bus_checker #(
		.BUS_CYCLES (BUS_CYCLES)
	) chk (
		.clk         (clk),
		.rst         (rst),
		.cpu_rd      (cpu_rd),
		.cpu_wr      (cpu_wr),
		.cpu_addr    (cpu_addr),
		.cpu_wdata   (cpu_wdata),
		.cpu_rdata   (cpu_rdata),
		.cpu_done    (cpu_done),
		.ext_a       (ext_a),
		.ext_d_out   (ext_d_out),
		.ext_d_oe    (ext_d_oe),
		.ext_rd_n    (ext_rd_n),
		.ext_wr_n    (ext_wr_n),
		.ext_cs_n    (ext_cs_n),
		.dma_active  (dma_active),
		.exp_valid   (exp_valid),
		.exp_rdata   (exp_rdata),
		.check_count (check_count),
		.error_count (error_count)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Cartridge, ROM below 8000 and RAM at A000-BFFF
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [7:0] rom_byte(input logic [15:0] a);
		return a[7:0] ^ a[15:8];
	endfunction

	always_comb begin
		if (ext_a < 16'h8000) begin
			ext_d_in = rom_byte(ext_a);
		end else if (ext_a >= 16'hA000 && ext_a < 16'hC000) begin
			ext_d_in = cart_ram[ext_a[12:0]];
		end else begin
			ext_d_in = 8'hFF;
		end
	end

	always @(posedge clk) begin
		if (!ext_wr_n && !ext_cs_n && ext_a >= 16'hA000 && ext_a < 16'hC000) begin
			cart_ram[ext_a[12:0]] <= ext_d_out;
		end
	end

	task automatic add_entry(input bus_op_t op, input logic [15:0] addr,
	                         input logic [7:0] wdata, input logic [7:0] exp);
		t_op.push_back(op);
		t_addr.push_back(addr);
		t_data.push_back(wdata);
		t_exp.push_back(exp);
	endtask

	task automatic build_table();
		logic [15:0] a;
		add_entry(op_rd, 16'h0000, 8'h00, rom_byte(16'h0000));
		add_entry(op_rd, 16'h1234, 8'h00, rom_byte(16'h1234));
		add_entry(op_rd, 16'h0150, 8'h00, rom_byte(16'h0150));
		add_entry(op_rd, 16'h7FFF, 8'h00, rom_byte(16'h7FFF));
		for (int k = 0; k < 10; k++) begin
			a = 16'($urandom()) & 16'h7FFF;
			add_entry(op_rd, a, 8'h00, rom_byte(a));
		end
		add_entry(op_wr, 16'hA000, 8'h5A, 8'h00);
		add_entry(op_wr, 16'hA001, 8'hC3, 8'h00);
		add_entry(op_wr, 16'hBFFF, 8'h7E, 8'h00);
		add_entry(op_rd, 16'hA000, 8'h00, 8'h5A);
		add_entry(op_rd, 16'hA001, 8'h00, 8'hC3);
		add_entry(op_rd, 16'hBFFF, 8'h00, 8'h7E);
		add_entry(op_rd, 16'hC000, 8'h00, 8'hFF);
		// Internal region
		add_entry(op_wr, 16'hFE00, 8'h11, 8'h00);
		add_entry(op_wr, 16'hFE10, 8'h22, 8'h00);
		add_entry(op_wr, 16'hFE9F, 8'h33, 8'h00);
		add_entry(op_rd, 16'hFE00, 8'h00, 8'h11);
		add_entry(op_rd, 16'hFE10, 8'h00, 8'h22);
		add_entry(op_rd, 16'hFE9F, 8'h00, 8'h33);
		add_entry(op_rd, 16'hFEA0, 8'h00, 8'hFF);
		add_entry(op_rd, 16'hFF00, 8'h00, 8'hFF);
		add_entry(op_rd, 16'hFF45, 8'h00, 8'hFF);
		add_entry(op_rd, 16'hFFFF, 8'h00, 8'hFF);
		// DMA of page 01, then accesses that overlap the copy
		add_entry(op_wr, 16'hFF46, 8'h01, 8'h00);
		add_entry(op_rd, 16'hFE05, 8'h00, 8'hFF);
		add_entry(op_rd, 16'h2345, 8'h00, rom_byte(16'h2345));
		for (int k = 0; k < OAM_BYTES; k++) begin
			add_entry(op_rd, 16'hFE00 + 16'(k), 8'h00, rom_byte(16'h0100 + 16'(k)));
		end
	endtask

	task automatic run_entry(input int i);
		@(posedge clk);
		cpu_addr  <= t_addr[i];
		cpu_wdata <= t_data[i];
		cpu_rd    <= (t_op[i] == op_rd);
		cpu_wr    <= (t_op[i] == op_wr);
		exp_valid <= (t_op[i] == op_rd);
		exp_rdata <= t_exp[i];
		do begin
			@(posedge clk);
		end while (!cpu_done);
		cpu_rd    <= 1'b0;
		cpu_wr    <= 1'b0;
		exp_valid <= 1'b0;
	endtask

	initial begin
		void'($urandom(32'h32ff_9689));
		rst       = 1'b1;
		cpu_rd    = 1'b0;
		cpu_wr    = 1'b0;
		cpu_addr  = 16'h0000;
		cpu_wdata = 8'h00;
		exp_valid = 1'b0;
		exp_rdata = 8'h00;
		build_table();
		// Each entry or DMA byte takes at most BUS_CYCLES + 8 clocks
		cycle_limit = (t_op.size() + OAM_BYTES) * (BUS_CYCLES + 8) + 400;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		repeat (3) @(posedge clk);
		for (int i = 0; i < t_op.size(); i++) begin
			run_entry(i);
		end
		repeat (2) @(posedge clk);
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0 && check_count > 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, a CPU access never completed", cycles);
			$display("Checks run: %0d, errors: %0d", check_count, error_count);
			$display("Checks failed");
			$finish;
		end
	end

endmodule

//--- gb_ext_bus_top.f
gb_bus_pkg.sv
ext_bus_if.sv
ext_cpu_busses.sv
oam_dma.sv
bus_arbiter.sv
oam_ram.sv
gb_ext_bus_top.sv
tb_ext_bus_checker.sv
tb_gb_ext_bus.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_gb_ext_bus
FILELIST  = gb_ext_bus_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "Checks failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
